// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;   // data or instruction word
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // base opcodes of RV32I
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        imm_none = 3'd0,
        imm_i    = 3'd1,
        imm_s    = 3'd2,
        imm_b    = 3'd3,
        imm_u    = 3'd4,
        imm_j    = 3'd5
    } imm_fmt_e;

    // instruction field positions
    localparam int OPCODE_MSB = 6;
    localparam int OPCODE_LSB = 0;
    localparam int RD_MSB     = 11;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_MSB    = 19;
    localparam int RS1_LSB    = 15;
    localparam int RS2_MSB    = 24;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_MSB = 31;
    localparam int FUNCT7_LSB = 25;

endpackage

// ==== rtl/regfile_pkg.sv ====
package regfile_pkg;

    localparam int NUM_REGS = 32;

    // index wide enough to address every register
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    localparam reg_idx_t ZERO_REG = '0;   // x0, hard-wired to zero

endpackage

// ==== rtl/regfile.sv ====
module regfile (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  we_i,
    input  regfile_pkg::reg_idx_t waddr_i,
    input  isa_pkg::word_t        wdata_i,
    input  regfile_pkg::reg_idx_t raddr_a_i,
    input  regfile_pkg::reg_idx_t raddr_b_i,
    output isa_pkg::word_t        rdata_a_o,
    output isa_pkg::word_t        rdata_b_o
);

    isa_pkg::word_t regs_q [regfile_pkg::NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != regfile_pkg::ZERO_REG)) begin
            regs_q[waddr_i] <= wdata_i;   // writes to x0 are dropped
        end
    end

    // no bypass, a write shows up one cycle later
    assign rdata_a_o = (raddr_a_i == regfile_pkg::ZERO_REG) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == regfile_pkg::ZERO_REG) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== rtl/imm_gen.sv ====
module imm_gen (
    input  isa_pkg::word_t    instr_i,
    output isa_pkg::word_t    imm_o,
    output isa_pkg::imm_fmt_e imm_fmt_o
);

    isa_pkg::opcode_e opcode;

    assign opcode = isa_pkg::opcode_e'(instr_i[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]);

    // format follows from the opcode alone
    always_comb begin
        case (opcode)
            isa_pkg::opc_jalr,
            isa_pkg::opc_load,
            isa_pkg::opc_op_imm,
            isa_pkg::opc_system: imm_fmt_o = isa_pkg::imm_i;
            isa_pkg::opc_store:  imm_fmt_o = isa_pkg::imm_s;
            isa_pkg::opc_branch: imm_fmt_o = isa_pkg::imm_b;
            isa_pkg::opc_lui,
            isa_pkg::opc_auipc:  imm_fmt_o = isa_pkg::imm_u;
            isa_pkg::opc_jal:    imm_fmt_o = isa_pkg::imm_j;
            default:             imm_fmt_o = isa_pkg::imm_none;   // op and unknown
        endcase
    end

    always_comb begin
        case (imm_fmt_o)
            isa_pkg::imm_i: imm_o = {{21{instr_i[31]}}, instr_i[30:20]};
            isa_pkg::imm_s: imm_o = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            isa_pkg::imm_b: begin
                // bit 0 is always zero for branch targets
                imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            isa_pkg::imm_u: imm_o = {instr_i[31:12], 12'h000};
            isa_pkg::imm_j: begin
                imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default:        imm_o = '0;
        endcase
    end

endmodule

// ==== rtl/decode_stage.sv ====
module decode_stage (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    input  logic                  ready_i,
    input  isa_pkg::word_t        instr_i,
    input  logic                  reg_we_i,
    input  regfile_pkg::reg_idx_t reg_waddr_i,
    input  isa_pkg::word_t        reg_wdata_i,
    output logic                  valid_o,
    output logic                  ready_o,
    output isa_pkg::opcode_e      opcode_o,
    output isa_pkg::funct3_t      funct3_o,
    output isa_pkg::funct7_t      funct7_o,
    output regfile_pkg::reg_idx_t rs1_o,
    output regfile_pkg::reg_idx_t rs2_o,
    output regfile_pkg::reg_idx_t rd_o,
    output isa_pkg::word_t        rs1_data_o,
    output isa_pkg::word_t        rs2_data_o,
    output isa_pkg::word_t        imm_o,
    output isa_pkg::imm_fmt_e     imm_fmt_o
);

    // the stage never stalls on its own
    assign ready_o = ready_i;
    assign valid_o = valid_i & ready_i;

    assign opcode_o = isa_pkg::opcode_e'(instr_i[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]);
    assign funct3_o = instr_i[isa_pkg::FUNCT3_MSB:isa_pkg::FUNCT3_LSB];
    assign funct7_o = instr_i[isa_pkg::FUNCT7_MSB:isa_pkg::FUNCT7_LSB];
    assign rs1_o    = instr_i[isa_pkg::RS1_MSB:isa_pkg::RS1_LSB];
    assign rs2_o    = instr_i[isa_pkg::RS2_MSB:isa_pkg::RS2_LSB];
    assign rd_o     = instr_i[isa_pkg::RD_MSB:isa_pkg::RD_LSB];

    imm_gen u_imm_gen (
        .instr_i   (instr_i),
        .imm_o     (imm_o),
        .imm_fmt_o (imm_fmt_o)
    );

    // operands read through the source indices
    regfile u_regfile (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .we_i      (reg_we_i),
        .waddr_i   (reg_waddr_i),
        .wdata_i   (reg_wdata_i),
        .raddr_a_i (rs1_o),
        .raddr_b_i (rs2_o),
        .rdata_a_o (rs1_data_o),
        .rdata_b_o (rs2_data_o)
    );

endmodule

// ==== rtl/id_ex_reg.sv ====
module id_ex_reg (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  ready_i,
    input  logic                  valid_i,
    input  isa_pkg::opcode_e      opcode_i,
    input  isa_pkg::funct3_t      funct3_i,
    input  isa_pkg::funct7_t      funct7_i,
    input  regfile_pkg::reg_idx_t rs1_i,
    input  regfile_pkg::reg_idx_t rs2_i,
    input  regfile_pkg::reg_idx_t rd_i,
    input  isa_pkg::word_t        rs1_data_i,
    input  isa_pkg::word_t        rs2_data_i,
    input  isa_pkg::word_t        imm_i,
    input  isa_pkg::imm_fmt_e     imm_fmt_i,
    output logic                  valid_o,
    output isa_pkg::opcode_e      opcode_o,
    output isa_pkg::funct3_t      funct3_o,
    output isa_pkg::funct7_t      funct7_o,
    output regfile_pkg::reg_idx_t rs1_o,
    output regfile_pkg::reg_idx_t rs2_o,
    output regfile_pkg::reg_idx_t rd_o,
    output isa_pkg::word_t        rs1_data_o,
    output isa_pkg::word_t        rs2_data_o,
    output isa_pkg::word_t        imm_o,
    output isa_pkg::imm_fmt_e     imm_fmt_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o    <= 1'b0;
            opcode_o   <= isa_pkg::opcode_e'('0);
            funct3_o   <= '0;
            funct7_o   <= '0;
            rs1_o      <= '0;
            rs2_o      <= '0;
            rd_o       <= '0;
            rs1_data_o <= '0;
            rs2_data_o <= '0;
            imm_o      <= '0;
            imm_fmt_o  <= isa_pkg::imm_none;
        end else if (ready_i) begin   // hold everything under back-pressure
            valid_o <= valid_i;
            if (valid_i) begin        // bubbles leave the payload alone
                opcode_o   <= opcode_i;
                funct3_o   <= funct3_i;
                funct7_o   <= funct7_i;
                rs1_o      <= rs1_i;
                rs2_o      <= rs2_i;
                rd_o       <= rd_i;
                rs1_data_o <= rs1_data_i;
                rs2_data_o <= rs2_data_i;
                imm_o      <= imm_i;
                imm_fmt_o  <= imm_fmt_i;
            end
        end
    end

endmodule

// ==== rtl/decode_top.sv ====
module decode_top (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    input  isa_pkg::word_t        instr_i,
    output logic                  ready_o,
    input  logic                  wb_we_i,
    input  regfile_pkg::reg_idx_t wb_rd_i,
    input  isa_pkg::word_t        wb_data_i,
    input  logic                  ex_ready_i,
    output logic                  ex_valid_o,
    output isa_pkg::opcode_e      ex_opcode_o,
    output isa_pkg::funct3_t      ex_funct3_o,
    output isa_pkg::funct7_t      ex_funct7_o,
    output regfile_pkg::reg_idx_t ex_rs1_o,
    output regfile_pkg::reg_idx_t ex_rs2_o,
    output regfile_pkg::reg_idx_t ex_rd_o,
    output isa_pkg::word_t        ex_rs1_data_o,
    output isa_pkg::word_t        ex_rs2_data_o,
    output isa_pkg::word_t        ex_imm_o,
    output isa_pkg::imm_fmt_e     ex_imm_fmt_o
);

    // decoded fields, combinational from instr_i
    logic                  id_valid;
    isa_pkg::opcode_e      id_opcode;
    isa_pkg::funct3_t      id_funct3;
    isa_pkg::funct7_t      id_funct7;
    regfile_pkg::reg_idx_t id_rs1;
    regfile_pkg::reg_idx_t id_rs2;
    regfile_pkg::reg_idx_t id_rd;
    isa_pkg::word_t        id_rs1_data;
    isa_pkg::word_t        id_rs2_data;
    isa_pkg::word_t        id_imm;
    isa_pkg::imm_fmt_e     id_imm_fmt;

    decode_stage u_decode_stage (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .valid_i     (valid_i),
        .ready_i     (ex_ready_i),
        .instr_i     (instr_i),
        .reg_we_i    (wb_we_i),
        .reg_waddr_i (wb_rd_i),
        .reg_wdata_i (wb_data_i),
        .valid_o     (id_valid),
        .ready_o     (ready_o),
        .opcode_o    (id_opcode),
        .funct3_o    (id_funct3),
        .funct7_o    (id_funct7),
        .rs1_o       (id_rs1),
        .rs2_o       (id_rs2),
        .rd_o        (id_rd),
        .rs1_data_o  (id_rs1_data),
        .rs2_data_o  (id_rs2_data),
        .imm_o       (id_imm),
        .imm_fmt_o   (id_imm_fmt)
    );

    id_ex_reg u_id_ex_reg (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .ready_i    (ex_ready_i),
        .valid_i    (id_valid),
        .opcode_i   (id_opcode),
        .funct3_i   (id_funct3),
        .funct7_i   (id_funct7),
        .rs1_i      (id_rs1),
        .rs2_i      (id_rs2),
        .rd_i       (id_rd),
        .rs1_data_i (id_rs1_data),
        .rs2_data_i (id_rs2_data),
        .imm_i      (id_imm),
        .imm_fmt_i  (id_imm_fmt),
        .valid_o    (ex_valid_o),
        .opcode_o   (ex_opcode_o),
        .funct3_o   (ex_funct3_o),
        .funct7_o   (ex_funct7_o),
        .rs1_o      (ex_rs1_o),
        .rs2_o      (ex_rs2_o),
        .rd_o       (ex_rd_o),
        .rs1_data_o (ex_rs1_data_o),
        .rs2_data_o (ex_rs2_data_o),
        .imm_o      (ex_imm_o),
        .imm_fmt_o  (ex_imm_fmt_o)
    );

endmodule

// ==== verification/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic fill_table();
    // instr, opcode, funct3, funct7, rs1, rs2, rd
    //   then the immediate and its format
    add_row(32'hfff08293, isa_pkg::opc_op_imm, 3'd0, 7'h7f, 5'd1, 5'd31, 5'd5,
            32'hffffffff, isa_pkg::imm_i);   // addi x5, x1, -1
    add_row(32'h002081b3, isa_pkg::opc_op, 3'd0, 7'h00, 5'd1, 5'd2, 5'd3,
            32'h00000000, isa_pkg::imm_none);   // add x3, x1, x2
    add_row(32'h41ef8533, isa_pkg::opc_op, 3'd0, 7'h20, 5'd31, 5'd30, 5'd10,
            32'h00000000, isa_pkg::imm_none);   // sub x10, x31, x30
    add_row(32'hff812303, isa_pkg::opc_load, 3'd2, 7'h7f, 5'd2, 5'd24, 5'd6,
            32'hfffffff8, isa_pkg::imm_i);   // lw x6, -8(x2)
    add_row(32'hfe71ae23, isa_pkg::opc_store, 3'd2, 7'h7f, 5'd3, 5'd7, 5'd28,
            32'hfffffffc, isa_pkg::imm_s);   // sw x7, -4(x3)
    add_row(32'hfe5208e3, isa_pkg::opc_branch, 3'd0, 7'h7f, 5'd4, 5'd5, 5'd17,
            32'hfffffff0, isa_pkg::imm_b);   // beq x4, x5, -16
    add_row(32'habcde437, isa_pkg::opc_lui, 3'd6, 7'h55, 5'd27, 5'd28, 5'd8,
            32'habcde000, isa_pkg::imm_u);   // lui x8, 0xabcde
    add_row(32'h801ff0ef, isa_pkg::opc_jal, 3'd7, 7'h40, 5'd31, 5'd1, 5'd1,
            32'hfffff800, isa_pkg::imm_j);   // jal x1, -2048
    add_row(32'h00008067, isa_pkg::opc_jalr, 3'd0, 7'h00, 5'd1, 5'd0, 5'd0,
            32'h00000000, isa_pkg::imm_i);   // jalr x0, 0(x1)
    add_row(32'h12345497, isa_pkg::opc_auipc, 3'd5, 7'h09, 5'd8, 5'd3, 5'd9,
            32'h12345000, isa_pkg::imm_u);   // auipc x9, 0x12345
    add_row(32'h00000073, isa_pkg::opc_system, 3'd0, 7'h00, 5'd0, 5'd0, 5'd0,
            32'h00000000, isa_pkg::imm_i);   // ecall
    // largest positive I immediate, rs1 is x0
    add_row(32'h7ff07613, isa_pkg::opc_op_imm, 3'd7, 7'h3f, 5'd0, 5'd31, 5'd12,
            32'h000007ff, isa_pkg::imm_i);   // andi x12, x0, 2047
endtask

`endif

// ==== verification/tb_decode_top.sv ====
module tb_decode_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 8;
    localparam int PRELOAD_CYCLES = regfile_pkg::NUM_REGS + 1;
    localparam int TIMEOUT_MARGIN = 50;

    logic                  clk_i = 1'b0;
    logic                  arst_n_i;
    logic                  valid_i;
    isa_pkg::word_t        instr_i;
    logic                  ready_o;
    logic                  wb_we_i;
    regfile_pkg::reg_idx_t wb_rd_i;
    isa_pkg::word_t        wb_data_i;
    logic                  ex_ready_i;
    logic                  ex_valid_o;
    isa_pkg::opcode_e      ex_opcode_o;
    isa_pkg::funct3_t      ex_funct3_o;
    isa_pkg::funct7_t      ex_funct7_o;
    regfile_pkg::reg_idx_t ex_rs1_o;
    regfile_pkg::reg_idx_t ex_rs2_o;
    regfile_pkg::reg_idx_t ex_rd_o;
    isa_pkg::word_t        ex_rs1_data_o;
    isa_pkg::word_t        ex_rs2_data_o;
    isa_pkg::word_t        ex_imm_o;
    isa_pkg::imm_fmt_e     ex_imm_fmt_o;

    // stimulus table with one entry per row in every queue
    isa_pkg::word_t        vec_instr[$];
    isa_pkg::opcode_e      vec_opcode[$];
    isa_pkg::funct3_t      vec_funct3[$];
    isa_pkg::funct7_t      vec_funct7[$];
    regfile_pkg::reg_idx_t vec_rs1[$];
    regfile_pkg::reg_idx_t vec_rs2[$];
    regfile_pkg::reg_idx_t vec_rd[$];
    isa_pkg::word_t        vec_imm[$];
    isa_pkg::imm_fmt_e     vec_imm_fmt[$];

    isa_pkg::word_t reg_model [regfile_pkg::NUM_REGS];   // expected register contents
    int             cycle_cnt = 0;
    int             cycle_limit;

    decode_top u_dut (.*);

    always #5 clk_i = ~clk_i;

    task automatic add_row(isa_pkg::word_t instr, isa_pkg::opcode_e opcode,
                           isa_pkg::funct3_t funct3, isa_pkg::funct7_t funct7,
                           regfile_pkg::reg_idx_t rs1, regfile_pkg::reg_idx_t rs2,
                           regfile_pkg::reg_idx_t rd, isa_pkg::word_t imm,
                           isa_pkg::imm_fmt_e imm_fmt);
        vec_instr.push_back(instr);
        vec_opcode.push_back(opcode);
        vec_funct3.push_back(funct3);
        vec_funct7.push_back(funct7);
        vec_rs1.push_back(rs1);
        vec_rs2.push_back(rs2);
        vec_rd.push_back(rd);
        vec_imm.push_back(imm);
        vec_imm_fmt.push_back(imm_fmt);
    endtask

    `include "tb_vectors.svh"

    task automatic end_with_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [31:0] act, logic [31:0] exp);
        $display("FAILED at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
        end_with_failure();
    endtask

    task automatic word_check(string name, isa_pkg::word_t act, isa_pkg::word_t exp);
        if (act !== exp) report_mismatch(name, act, exp);
    endtask

    task automatic idx_check(string name, regfile_pkg::reg_idx_t act,
                             regfile_pkg::reg_idx_t exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic opcode_check(string name, isa_pkg::opcode_e act, isa_pkg::opcode_e exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic fmt_check(string name, isa_pkg::imm_fmt_e act, isa_pkg::imm_fmt_e exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic f3_check(string name, isa_pkg::funct3_t act, isa_pkg::funct3_t exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic f7_check(string name, isa_pkg::funct7_t act, isa_pkg::funct7_t exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    task automatic bit_check(string name, logic act, logic exp);
        if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
    endtask

    // all ex_* outputs against row r with operands from the model
    task automatic row_check(int r, logic exp_valid);
        bit_check("ex_valid_o", ex_valid_o, exp_valid);
        opcode_check("ex_opcode_o", ex_opcode_o, vec_opcode[r]);
        f3_check("ex_funct3_o", ex_funct3_o, vec_funct3[r]);
        f7_check("ex_funct7_o", ex_funct7_o, vec_funct7[r]);
        idx_check("ex_rs1_o", ex_rs1_o, vec_rs1[r]);
        idx_check("ex_rs2_o", ex_rs2_o, vec_rs2[r]);
        idx_check("ex_rd_o", ex_rd_o, vec_rd[r]);
        word_check("ex_rs1_data_o", ex_rs1_data_o, reg_model[vec_rs1[r]]);
        word_check("ex_rs2_data_o", ex_rs2_data_o, reg_model[vec_rs2[r]]);
        word_check("ex_imm_o", ex_imm_o, vec_imm[r]);
        fmt_check("ex_imm_fmt_o", ex_imm_fmt_o, vec_imm_fmt[r]);
    endtask

    task automatic reset_check();
        bit_check("ex_valid_o", ex_valid_o, 1'b0);
        opcode_check("ex_opcode_o", ex_opcode_o, isa_pkg::opcode_e'(0));
        f3_check("ex_funct3_o", ex_funct3_o, '0);
        f7_check("ex_funct7_o", ex_funct7_o, '0);
        idx_check("ex_rs1_o", ex_rs1_o, '0);
        idx_check("ex_rs2_o", ex_rs2_o, '0);
        idx_check("ex_rd_o", ex_rd_o, '0);
        word_check("ex_rs1_data_o", ex_rs1_data_o, '0);
        word_check("ex_rs2_data_o", ex_rs2_data_o, '0);
        word_check("ex_imm_o", ex_imm_o, '0);
        fmt_check("ex_imm_fmt_o", ex_imm_fmt_o, isa_pkg::imm_none);
    endtask

    task automatic preload_regs();
        isa_pkg::word_t wdata;
        for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
            wdata = $urandom;
            if (i == 0) wdata = wdata | 32'h1;   // x0 also gets a nonzero write
            @(posedge clk_i);
            wb_we_i   <= 1'b1;
            wb_rd_i   <= regfile_pkg::reg_idx_t'(i);
            wb_data_i <= wdata;
            if (i != 0) reg_model[i] = wdata;
        end
        @(posedge clk_i);
        wb_we_i <= 1'b0;
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            end_with_failure();
        end
    end

    initial begin
        int gap;
        void'($urandom(49));
        arst_n_i   <= 1'b0;
        valid_i    <= 1'b0;
        instr_i    <= '0;
        wb_we_i    <= 1'b0;
        wb_rd_i    <= '0;
        wb_data_i  <= '0;
        ex_ready_i <= 1'b0;
        for (int i = 0; i < regfile_pkg::NUM_REGS; i++) reg_model[i] = '0;
        fill_table();
        cycle_limit = RESET_CYCLES + 4 * vec_instr.size() + PRELOAD_CYCLES + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        reset_check();
        bit_check("ready_o", ready_o, 1'b0);
        @(posedge clk_i);
        ex_ready_i <= 1'b1;
        @(negedge clk_i);
        bit_check("ready_o", ready_o, 1'b1);   // follows ex_ready_i in the same cycle
        reset_check();

        preload_regs();

        for (int r = 0; r < vec_instr.size(); r++) begin
            gap = $urandom_range(0, 3);
            @(posedge clk_i);
            valid_i    <= 1'b1;
            instr_i    <= vec_instr[r];
            ex_ready_i <= 1'b1;
            @(posedge clk_i);   // accepted here
            ex_ready_i <= (gap == 0);
            if (gap == 0) begin
                valid_i <= 1'b0;
            end else begin
                instr_i <= vec_instr[(r + 1) % vec_instr.size()];   // pending, not accepted
            end
            @(negedge clk_i);
            bit_check("ready_o", ready_o, gap == 0);
            row_check(r, 1'b1);
            for (int k = 1; k <= gap; k++) begin
                @(posedge clk_i);
                if (k == gap) begin
                    ex_ready_i <= 1'b1;
                    valid_i    <= 1'b0;
                end
                @(negedge clk_i);
                bit_check("ready_o", ready_o, k == gap);
                row_check(r, 1'b1);   // item held under back-pressure
            end
            // bubble goes through while the payload stays
            @(posedge clk_i);
            @(negedge clk_i);
            row_check(r, 1'b0);
        end

        $display("No errors");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verification
rtl/isa_pkg.sv
rtl/regfile_pkg.sv
rtl/regfile.sv
rtl/imm_gen.sv
rtl/decode_stage.sv
rtl/id_ex_reg.sv
rtl/decode_top.sv
verification/tb_decode_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_decode_top
FILELIST  := project.f
FLAGS     := --binary --timing
BUILD_DIR := obj_dir
PASS_MSG  := No errors
SOURCES   := $(wildcard rtl/*.sv verification/*.sv verification/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
